/* include/mau_defs.svh */
// Memory access unit constants

`ifndef MAU_DEFS_SVH
`define MAU_DEFS_SVH

// Data path width.
`define XLEN 64

// Major opcodes for loads and stores.
`define OPC_LOAD  7'b0000011
`define OPC_STORE 7'b0100011

// CLINT register addresses.
`define CLINT_MSIP_ADDR     64'h0000_0000_0200_0000
`define CLINT_MTIMECMP_ADDR 64'h0000_0000_0200_4000
`define CLINT_MTIME_ADDR    64'h0000_0000_0200_BFF8

// Local data RAM window, 512 doublewords.
`define RAM_BASE   64'h0000_0000_8000_0000
`define RAM_DWORDS 512
`define RAM_AW     9

`endif

/* verilog/mau_pkg.sv */
// Memory access unit types

`default_nettype none

`include "mau_defs.svh"

package mau_pkg;

	// Encoded to match funct3[1:0].
	typedef enum logic [1:0] {
		SIZE_BYTE   = 2'd0,
		SIZE_HALF   = 2'd1,
		SIZE_WORD   = 2'd2,
		SIZE_DOUBLE = 2'd3
	} mem_size_t;

	typedef enum logic [2:0] {
		REGION_NONE     = 3'd0,
		REGION_RAM      = 3'd1,
		REGION_MSIP     = 3'd2,
		REGION_MTIMECMP = 3'd3,
		REGION_MTIME    = 3'd4
	} mem_region_t;

	typedef struct packed {
		logic               load;
		logic               store;
		mem_size_t          size;
		logic               sign;
		mem_region_t        region;
		logic [2:0]         offset;
		logic [`RAM_AW-1:0] index;
		logic [`XLEN-1:0]   wdata;
	} mem_req_t;

	// One RAM write, already placed in its byte lanes.
	typedef struct packed {
		logic               we;
		logic [`RAM_AW-1:0] index;
		logic [7:0]         mask;
		logic [`XLEN-1:0]   data;
	} store_lane_t;

endpackage

`default_nettype wire

/* verilog/mem_decode.sv */
// Memory request decoder

`timescale 1ns/1ps
`default_nettype none

`include "mau_defs.svh"

module mem_decode (
	input  wire logic [6:0]       opcode,
	input  wire logic [2:0]       funct3,
	input  wire logic [`XLEN-1:0] alu_result,
	input  wire logic [`XLEN-1:0] src2,
	output mau_pkg::mem_req_t     req
);
	import mau_pkg::*;

	logic        f3_load_ok;
	logic        f3_store_ok;
	logic        in_ram;
	mem_region_t region;

	// Loads take every funct3 but 3'b111. Stores stop at doubleword.
	assign f3_load_ok  = funct3 != 3'b111;
	assign f3_store_ok = funct3[2] == 1'b0;

	assign in_ram = (alu_result >= `RAM_BASE) &&
		(alu_result < `RAM_BASE + `RAM_DWORDS * 8);

	// CLINT registers match on the exact address only.
	always_comb begin
		if (alu_result == `CLINT_MSIP_ADDR) begin
			region = REGION_MSIP;
		end else if (alu_result == `CLINT_MTIMECMP_ADDR) begin
			region = REGION_MTIMECMP;
		end else if (alu_result == `CLINT_MTIME_ADDR) begin
			region = REGION_MTIME;
		end else if (in_ram) begin
			region = REGION_RAM;
		end else begin
			region = REGION_NONE;
		end
	end

	always_comb begin
		req.load   = (opcode == `OPC_LOAD) && f3_load_ok;
		req.store  = (opcode == `OPC_STORE) && f3_store_ok;
		req.size   = mem_size_t'(funct3[1:0]);
		req.sign   = ~funct3[2];
		req.region = region;
		req.offset = alu_result[2:0];
		req.index  = alu_result[`RAM_AW+2:3];
		req.wdata  = src2;
	end

endmodule

`default_nettype wire

/* verilog/store_align.sv */
// Store lane alignment

`timescale 1ns/1ps
`default_nettype none

`include "mau_defs.svh"

module store_align (
	input  wire mau_pkg::mem_req_t req,
	output mau_pkg::store_lane_t   wr
);
	import mau_pkg::*;

	logic [7:0] size_mask;
	logic       ram_store;

	assign ram_store = req.store && (req.region == REGION_RAM);

	always_comb begin
		case (req.size)
			SIZE_BYTE: size_mask = 8'b0000_0001;
			SIZE_HALF: size_mask = 8'b0000_0011;
			SIZE_WORD: size_mask = 8'b0000_1111;
			default:   size_mask = 8'b1111_1111;
		endcase
	end

	always_comb begin
		wr.we    = ram_store;
		wr.index = req.index;
		if (req.size == SIZE_DOUBLE) begin
			wr.mask = 8'hff;
			wr.data = req.wdata;
		end else begin
			// Lanes shifted past byte 7 fall off the top.
			wr.mask = size_mask << req.offset;
			wr.data = req.wdata << {req.offset, 3'b000};
		end
		if (!ram_store) begin
			wr.mask = 8'h00;
		end
	end

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
// Byte-masked data RAM

`timescale 1ns/1ps
`default_nettype none

`include "mau_defs.svh"

module data_ram (
	input  wire logic                clk,
	input  wire mau_pkg::store_lane_t wr,
	input  wire logic [`RAM_AW-1:0]  rd_index,
	output logic [`XLEN-1:0]         rdata
);
	logic [`XLEN-1:0] mem [`RAM_DWORDS];

	// A same-address read returns the old doubleword.
	always_ff @(posedge clk) begin
		rdata <= mem[rd_index];
	end

	always_ff @(posedge clk) begin
		if (wr.we) begin
			for (int b = 0; b < 8; b++) begin
				if (wr.mask[b]) begin
					mem[wr.index][b*8 +: 8] <= wr.data[b*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/clint.sv */
// Core-local interruptor

`timescale 1ns/1ps
`default_nettype none

`include "mau_defs.svh"

module clint (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire mau_pkg::mem_req_t req,
	output logic [`XLEN-1:0]       rdata,
	output logic                   msip,
	output logic                   mtip
);
	import mau_pkg::*;

	logic [`XLEN-1:0] mtime;
	logic [`XLEN-1:0] mtimecmp;
	logic             wr_msip;
	logic             wr_mtimecmp;
	logic             wr_mtime;

	// Stores write whole registers and ignore the byte mask.
	assign wr_msip     = req.store && (req.region == REGION_MSIP);
	assign wr_mtimecmp = req.store && (req.region == REGION_MTIMECMP);
	assign wr_mtime    = req.store && (req.region == REGION_MTIME);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			msip     <= 1'b0;
			mtimecmp <= '1;
		end else begin
			if (wr_msip) begin
				msip <= req.wdata[0];
			end
			if (wr_mtimecmp) begin
				mtimecmp <= req.wdata;
			end
		end
	end

	// A store to mtime replaces the increment.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mtime <= '0;
		end else if (wr_mtime) begin
			mtime <= req.wdata;
		end else begin
			mtime <= mtime + 1'b1;
		end
	end

	// Read value reflects the registers as they stood before this edge.
	always_ff @(posedge clk) begin
		case (req.region)
			REGION_MSIP:     rdata <= {{(`XLEN-1){1'b0}}, msip};
			REGION_MTIMECMP: rdata <= mtimecmp;
			REGION_MTIME:    rdata <= mtime;
			default:         rdata <= '0;
		endcase
	end

	assign mtip = mtime >= mtimecmp;

endmodule

`default_nettype wire

/* verilog/load_extend.sv */
// Load field extraction

`timescale 1ns/1ps
`default_nettype none

`include "mau_defs.svh"

module load_extend (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire mau_pkg::mem_req_t req,
	input  wire logic [`XLEN-1:0] ram_rdata,
	input  wire logic [`XLEN-1:0] clint_rdata,
	output logic [`XLEN-1:0]      ld_data,
	output logic                  ld_valid
);
	import mau_pkg::*;

	mem_region_t      q_region;
	mem_size_t        q_size;
	logic             q_sign;
	logic [2:0]       q_offset;
	logic [`XLEN-1:0] src;
	logic [`XLEN-1:0] shifted;
	logic             in_range;

	// Load context for the cycle in which the read data returns.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ld_valid <= 1'b0;
			q_region <= REGION_NONE;
			q_size   <= SIZE_BYTE;
			q_sign   <= 1'b0;
			q_offset <= 3'd0;
		end else begin
			ld_valid <= req.load;
			q_region <= req.region;
			q_size   <= req.size;
			q_sign   <= req.sign;
			q_offset <= req.offset;
		end
	end

	always_comb begin
		case (q_region)
			REGION_RAM:                                src = ram_rdata;
			REGION_MSIP, REGION_MTIMECMP, REGION_MTIME: src = clint_rdata;
			default:                                   src = '0;
		endcase
		shifted = src >> {q_offset, 3'b000};
	end

	// A field that runs past byte 7 reads as zero.
	always_comb begin
		case (q_size)
			SIZE_HALF: in_range = q_offset != 3'd7;
			SIZE_WORD: in_range = q_offset <= 3'd4;
			default:   in_range = 1'b1;
		endcase
	end

	always_comb begin
		case (q_size)
			SIZE_BYTE: ld_data = {{(`XLEN-8){q_sign & shifted[7]}}, shifted[7:0]};
			SIZE_HALF: ld_data = {{(`XLEN-16){q_sign & shifted[15]}}, shifted[15:0]};
			SIZE_WORD: ld_data = {{(`XLEN-32){q_sign & shifted[31]}}, shifted[31:0]};
			default:   ld_data = src;
		endcase
		if (!in_range) begin
			ld_data = '0;
		end
	end

endmodule

`default_nettype wire

/* verilog/mau_top.sv */
// Memory access unit top

`timescale 1ns/1ps
`default_nettype none

`include "mau_defs.svh"

module mau_top (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire logic [6:0]       opcode,
	input  wire logic [2:0]       funct3,
	input  wire logic [`XLEN-1:0] src2,
	input  wire logic [`XLEN-1:0] alu_result,
	output logic [`XLEN-1:0]      ld_data,
	output logic                  ld_valid,
	output logic                  msip,
	output logic                  mtip
);
	import mau_pkg::*;

	mem_req_t         req;
	store_lane_t      wr;
	logic [`XLEN-1:0] ram_rdata;
	logic [`XLEN-1:0] clint_rdata;

	mem_decode u_decode (
		.opcode     (opcode),
		.funct3     (funct3),
		.alu_result (alu_result),
		.src2       (src2),
		.req        (req)
	);

	store_align u_store_align (
		.req (req),
		.wr  (wr)
	);

	// RAM is read at the request index every cycle.
	data_ram u_data_ram (
		.clk      (clk),
		.wr       (wr),
		.rd_index (req.index),
		.rdata    (ram_rdata)
	);

	clint u_clint (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.rdata  (clint_rdata),
		.msip   (msip),
		.mtip   (mtip)
	);

	load_extend u_load_extend (
		.clk         (clk),
		.arst_n      (arst_n),
		.req         (req),
		.ram_rdata   (ram_rdata),
		.clint_rdata (clint_rdata),
		.ld_data     (ld_data),
		.ld_valid    (ld_valid)
	);

endmodule

`default_nettype wire

/* dv/mau_tb.sv */
// Memory access unit testbench

`timescale 1ns/1ps
`default_nettype none

`include "mau_defs.svh"

module mau_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int WIN_DWORDS   = 32;
	localparam int RAND_OPS     = 400;
	localparam int UNMAPPED_OPS = 16;
	localparam int CLINT_CYCLES = 48;
	// Random ops take up to two cycles and unmapped ops three.
	localparam int TEST_CYCLES  = 4 + WIN_DWORDS + 2 * RAND_OPS + 3 * UNMAPPED_OPS + CLINT_CYCLES;
	localparam logic [63:0] WIN_BASE = `RAM_BASE + 64'h200;

	localparam int RG_NONE     = 0;
	localparam int RG_RAM      = 1;
	localparam int RG_MSIP     = 2;
	localparam int RG_MTIMECMP = 3;
	localparam int RG_MTIME    = 4;

	logic             clk;
	logic             arst_n;
	logic [6:0]       opcode;
	logic [2:0]       funct3;
	logic [`XLEN-1:0] src2;
	logic [`XLEN-1:0] alu_result;
	logic [`XLEN-1:0] ld_data;
	logic             ld_valid;
	logic             msip;
	logic             mtip;

	integer      seed;
	logic [7:0]  ram_model [WIN_DWORDS*8];
	logic        model_msip;
	logic [63:0] model_mtimecmp;
	logic [63:0] model_mtime;
	logic [63:0] exp_q [$];

	mau_top DUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.opcode     (opcode),
		.funct3     (funct3),
		.src2       (src2),
		.alu_result (alu_result),
		.ld_data    (ld_data),
		.ld_valid   (ld_valid),
		.msip       (msip),
		.mtip       (mtip)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
				$time, name, expected, actual));
		end
	endtask

	function automatic int region_of(input logic [63:0] addr);
		if (addr == `CLINT_MSIP_ADDR) return RG_MSIP;
		if (addr == `CLINT_MTIMECMP_ADDR) return RG_MTIMECMP;
		if (addr == `CLINT_MTIME_ADDR) return RG_MTIME;
		if (addr >= `RAM_BASE && addr < `RAM_BASE + `RAM_DWORDS * 8) return RG_RAM;
		return RG_NONE;
	endfunction

	function automatic logic [63:0] ram_dword(input int slot);
		logic [63:0] dw;
		for (int b = 0; b < 8; b++) begin
			dw[b*8 +: 8] = ram_model[slot*8 + b];
		end
		return dw;
	endfunction

	// Returns zero for a field that runs past byte 7.
	function automatic logic [63:0] extract_field(input logic [63:0] dw, input logic [1:0] size,
		input logic sign_ext, input logic [2:0] offset);
		int          nbytes;
		logic [63:0] field;
		nbytes = 1 << size;
		field  = 64'd0;
		if (size == 2'd3) begin
			return dw;
		end
		for (int i = 0; i < nbytes; i++) begin
			if (int'(offset) + i > 7) begin
				return 64'd0;
			end
			field[i*8 +: 8] = dw[(int'(offset) + i)*8 +: 8];
		end
		for (int i = nbytes * 8; i < 64; i++) begin
			field[i] = sign_ext & field[nbytes*8 - 1];
		end
		return field;
	endfunction

	task automatic write_ram_model(input int slot, input logic [1:0] size,
		input logic [2:0] offset, input logic [63:0] data);
		int nbytes;
		nbytes = 1 << size;
		for (int i = 0; i < nbytes; i++) begin
			// Doublewords start at lane 0 whatever the offset.
			if (size == 2'd3) begin
				ram_model[slot*8 + i] = data[i*8 +: 8];
			end else if (int'(offset) + i <= 7) begin
				ram_model[slot*8 + int'(offset) + i] = data[i*8 +: 8];
			end
		end
	endtask

	task automatic check_load_result();
		logic [63:0] expected;
		if (ld_valid !== 1'b0 && ld_valid !== 1'b1) begin
			stop_with_failure("ld_valid is unknown after a clock edge");
		end else if (ld_valid) begin
			if (exp_q.size() == 0) begin
				stop_with_failure("ld_valid pulsed with no load in flight");
			end else begin
				expected = exp_q.pop_front();
				check_value("ld_data", expected, ld_data);
			end
		end else if (exp_q.size() != 0) begin
			stop_with_failure("a load got no ld_valid pulse on the following cycle");
		end
	endtask

	// Presents one request, then checks the outputs 2 ns after its edge.
	task automatic do_cycle(input logic [6:0] op, input logic [2:0] f3,
		input logic [63:0] addr, input logic [63:0] data);
		logic        is_load;
		logic        is_store;
		int          region;
		int          slot;
		logic [63:0] src;
		is_load    = (op == `OPC_LOAD) && (f3 != 3'd7);
		is_store   = (op == `OPC_STORE) && !f3[2];
		region     = region_of(addr);
		slot       = int'((addr - WIN_BASE) >> 3);
		opcode     = op;
		funct3     = f3;
		alu_result = addr;
		src2       = data;
		@(posedge clk);
		#2;
		if (is_load) begin
			case (region)
				RG_RAM:      src = ram_dword(slot);
				RG_MSIP:     src = {63'd0, model_msip};
				RG_MTIMECMP: src = model_mtimecmp;
				RG_MTIME:    src = model_mtime;
				default:     src = 64'd0;
			endcase
			exp_q.push_back(extract_field(src, f3[1:0], !f3[2], addr[2:0]));
		end
		check_load_result();
		if (is_store) begin
			case (region)
				RG_RAM:      write_ram_model(slot, f3[1:0], addr[2:0], data);
				RG_MSIP:     model_msip = data[0];
				RG_MTIMECMP: model_mtimecmp = data;
				default:     ;
			endcase
		end
		model_mtime = (is_store && region == RG_MTIME) ? data : model_mtime + 64'd1;
		check_value("msip", {63'd0, model_msip}, {63'd0, msip});
		check_value("mtip", {63'd0, model_mtime >= model_mtimecmp}, {63'd0, mtip});
	endtask

	task automatic idle_cycle();
		do_cycle(7'd0, 3'd0, 64'd0, 64'd0);
	endtask

	task automatic random_ram_op();
		logic [31:0] r;
		logic [63:0] addr;
		logic [63:0] data;
		logic [2:0]  f3;
		r    = $random(seed);
		addr = WIN_BASE + {56'd0, r[7:0]};
		data = {$random(seed), $random(seed)};
		f3   = r[11:9];
		if (r[8]) begin
			do_cycle(`OPC_STORE, {1'b0, f3[1:0]}, addr, data);
			// Read back on the next edge now and then.
			if (r[12]) begin
				do_cycle(`OPC_LOAD, (r[15:13] == 3'd7) ? 3'd3 : r[15:13], addr, 64'd0);
			end
		end else begin
			do_cycle(`OPC_LOAD, (f3 == 3'd7) ? 3'd4 : f3, addr, 64'd0);
		end
	endtask

	task automatic unmapped_op();
		logic [31:0] r;
		logic [63:0] addr;
		logic [2:0]  f3;
		r  = $random(seed);
		f3 = (r[11:9] == 3'd7) ? 3'd3 : r[11:9];
		case (r[1:0])
			// Same RAM index bits as a window slot.
			2'd0:    addr = `RAM_BASE + `RAM_DWORDS * 8 + 64'h200 + {56'd0, r[8:4], 3'd0};
			2'd1:    addr = `RAM_BASE - 64'd8;
			2'd2:    addr = `CLINT_MSIP_ADDR + 64'd8;
			default: addr = `CLINT_MTIMECMP_ADDR + 64'd4;
		endcase
		do_cycle(`OPC_STORE, 3'd3, addr, {$random(seed), $random(seed)});
		do_cycle(`OPC_LOAD, f3, addr, 64'd0);
		do_cycle(`OPC_LOAD, 3'd3, WIN_BASE + {56'd0, r[8:4], 3'd0}, 64'd0);
	endtask

	task automatic clint_checks();
		int k;
		k = 4 + ($random(seed) & 7);
		do_cycle(`OPC_STORE, 3'd3, `CLINT_MSIP_ADDR, 64'd1);
		do_cycle(`OPC_LOAD, 3'd2, `CLINT_MSIP_ADDR, 64'd0);
		do_cycle(`OPC_STORE, 3'd2, `CLINT_MSIP_ADDR, 64'hffff_fffe);
		do_cycle(`OPC_LOAD, 3'd3, `CLINT_MSIP_ADDR, 64'd0);
		do_cycle(`OPC_STORE, 3'd3, `CLINT_MTIMECMP_ADDR, {1'b1, 31'd0, $random(seed)});
		do_cycle(`OPC_LOAD, 3'd3, `CLINT_MTIMECMP_ADDR, 64'd0);
		do_cycle(`OPC_LOAD, 3'd6, `CLINT_MTIMECMP_ADDR, 64'd0);
		// Two mtime reads k cycles apart.
		do_cycle(`OPC_LOAD, 3'd3, `CLINT_MTIME_ADDR, 64'd0);
		repeat (k - 1) idle_cycle();
		do_cycle(`OPC_LOAD, 3'd3, `CLINT_MTIME_ADDR, 64'd0);
		do_cycle(`OPC_STORE, 3'd3, `CLINT_MTIMECMP_ADDR, model_mtime + 64'd3);
		repeat (6) idle_cycle();
		check_value("mtip", 64'd1, {63'd0, mtip});
		do_cycle(`OPC_STORE, 3'd3, `CLINT_MTIMECMP_ADDR, 64'hffff_ffff_ffff_ffff);
		check_value("mtip", 64'd0, {63'd0, mtip});
	endtask

	initial begin
		#(CLK_PERIOD * (TEST_CYCLES + 100));
		stop_with_failure("Timeout: the test sequence did not finish in time");
	end

	initial begin
		seed           = 32'h5642;
		arst_n         = 1'b0;
		opcode         = 7'd0;
		funct3         = 3'd0;
		src2           = 64'd0;
		alu_result     = 64'd0;
		model_msip     = 1'b0;
		model_mtimecmp = 64'hffff_ffff_ffff_ffff;
		model_mtime    = 64'd0;
		repeat (2) @(posedge clk);
		#2;
		arst_n = 1'b1;
		check_value("ld_valid", 64'd0, {63'd0, ld_valid});
		check_value("msip", 64'd0, {63'd0, msip});
		check_value("mtip", 64'd0, {63'd0, mtip});
		// Fill the window so later loads read known data.
		for (int s = 0; s < WIN_DWORDS; s++) begin
			do_cycle(`OPC_STORE, 3'd3, WIN_BASE + 64'(s * 8), {$random(seed), $random(seed)});
		end
		repeat (RAND_OPS) random_ram_op();
		repeat (UNMAPPED_OPS) unmapped_op();
		clint_checks();
		idle_cycle();
		if (exp_q.size() != 0) begin
			stop_with_failure("loads were still outstanding at the end of the run");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* mau.f */
+incdir+include
verilog/mau_pkg.sv
verilog/mem_decode.sv
verilog/store_align.sv
verilog/data_ram.sv
verilog/clint.sv
verilog/load_extend.sv
verilog/mau_top.sv
dv/mau_tb.sv

/* Makefile */
# Verilator build and run for the memory access unit.

SRCS := $(wildcard verilog/*.sv dv/*.sv include/*.svh)

.PHONY: all run clean

all: obj_dir/Vmau_tb

# Rebuilt only when a source or the file list changes.
obj_dir/Vmau_tb: mau.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module mau_tb -f mau.f

# Exit status of the simulator is the test result.
run: obj_dir/Vmau_tb
	./obj_dir/Vmau_tb

clean:
	rm -rf obj_dir
